// ==== common/axi_wr_pkg.sv ====
`default_nettype none

package axi_wr_pkg;

  localparam int num_mgr = 3;
  localparam int addr_w = 20;
  localparam int data_w = 16;
  localparam int mgr_id_w = 4;
  localparam int mgr_idx_w = $clog2(num_mgr);
  localparam int sub_id_w = mgr_id_w + mgr_idx_w;

  typedef logic [mgr_idx_w-1:0] mgr_idx_t;

  // Address beat as issued by a manager
  typedef struct packed {
    logic [mgr_id_w-1:0] id;
    logic [addr_w-1:0]   addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } mgr_aw_t;

  // Same beat with the manager index above the ID
  typedef struct packed {
    logic [sub_id_w-1:0] id;
    logic [addr_w-1:0]   addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } sub_aw_t;

  typedef struct packed {
    logic [data_w-1:0]   data;
    logic [data_w/8-1:0] strb;
    logic                last;
  } w_beat_t;

  typedef struct packed {
    logic [sub_id_w-1:0] id;
    logic [1:0]          resp;
  } sub_b_t;

  typedef struct packed {
    logic [mgr_id_w-1:0] id;
    logic [1:0]          resp;
  } mgr_b_t;

  // Routed response held in the B slice, sel is one-hot per manager
  typedef struct packed {
    logic [num_mgr-1:0]   sel;
    mgr_b_t [num_mgr-1:0] b;
  } mgr_b_bundle_t;

endpackage

`default_nettype wire

// ==== hw/axi_wr_grant_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_wr_grant_ctrl
  import axi_wr_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_mgr-1:0] aw_req,
  input  logic               aw_slot_ready,
  input  logic               w_done,
  output mgr_idx_t           grant_idx,
  output logic               aw_grant,
  output logic               w_open
);

  mgr_idx_t rr_ptr;
  mgr_idx_t lock_idx;
  mgr_idx_t pick_idx;
  logic     pick_valid;
  logic     locked;

  function automatic mgr_idx_t next_idx(input mgr_idx_t idx);
    if (idx == mgr_idx_t'(num_mgr - 1)) begin
      return '0;
    end
    return idx + mgr_idx_t'(1);
  endfunction

  // First requester at or after the pointer
  always_comb begin
    int cand;
    pick_idx = rr_ptr;
    pick_valid = 1'b0;
    for (int i = 0; i < num_mgr; i++) begin
      cand = int'(rr_ptr) + i;
      if (cand >= num_mgr) begin
        cand = cand - num_mgr;
      end
      if (!pick_valid && aw_req[cand]) begin
        pick_idx = mgr_idx_t'(cand);
        pick_valid = 1'b1;
      end
    end
  end

  // Only one burst in flight on AW/W at a time
  assign aw_grant = !locked && pick_valid && aw_slot_ready;
  assign grant_idx = locked ? lock_idx : pick_idx;
  assign w_open = locked;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked   <= 1'b0;
      lock_idx <= '0;
      rr_ptr   <= '0;
    end else if (aw_grant) begin
      locked   <= 1'b1;
      lock_idx <= pick_idx;
    end else if (locked && w_done) begin
      // Release and move past the manager just served
      locked <= 1'b0;
      rr_ptr <= next_idx(lock_idx);
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Accept when empty or when draining this cycle
  assign in_ready = !full || out_ready;
  assign out_valid = full;
  assign out_data = data_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_aw_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_aw_mux
  import axi_wr_pkg::*;
(
  input  logic                 [num_mgr-1:0] mgr_aw_valid,
  input  mgr_aw_t [num_mgr-1:0]              mgr_aw,
  output logic                 [num_mgr-1:0] mgr_aw_ready,
  input  mgr_idx_t                           grant_idx,
  input  logic                               aw_grant,
  output logic                               aw_out_valid,
  output sub_aw_t                            aw_out
);

  mgr_aw_t sel_aw;

  assign sel_aw = mgr_aw[grant_idx];

  assign aw_out_valid = aw_grant && mgr_aw_valid[grant_idx];

  // Manager index goes above the original ID
  assign aw_out.id = {grant_idx, sel_aw.id};
  assign aw_out.addr = sel_aw.addr;
  assign aw_out.len = sel_aw.len;
  assign aw_out.size = sel_aw.size;
  assign aw_out.burst = sel_aw.burst;

  always_comb begin
    for (int i = 0; i < num_mgr; i++) begin
      mgr_aw_ready[i] = aw_grant && (grant_idx == mgr_idx_t'(i));
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_w_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_w_mux
  import axi_wr_pkg::*;
(
  input  logic                 [num_mgr-1:0] mgr_w_valid,
  input  w_beat_t [num_mgr-1:0]              mgr_w,
  output logic                 [num_mgr-1:0] mgr_w_ready,
  input  mgr_idx_t                           grant_idx,
  input  logic                               w_open,
  output logic                               sub_w_valid,
  output w_beat_t                            sub_w,
  input  logic                               sub_w_ready,
  output logic                               w_done
);

  assign sub_w_valid = w_open && mgr_w_valid[grant_idx];
  assign sub_w = mgr_w[grant_idx];

  // Ready only reaches the locked manager
  always_comb begin
    for (int i = 0; i < num_mgr; i++) begin
      mgr_w_ready[i] = w_open && sub_w_ready && (grant_idx == mgr_idx_t'(i));
    end
  end

  assign w_done = sub_w_valid && sub_w_ready && sub_w.last;

endmodule

`default_nettype wire

// ==== hw/axi_b_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_b_route
  import axi_wr_pkg::*;
(
  input  logic                              in_valid,
  input  sub_b_t                            in_b,
  output logic                              in_ready,
  output logic                [num_mgr-1:0] out_valid,
  output mgr_b_t [num_mgr-1:0]              out_b,
  input  logic                [num_mgr-1:0] out_ready
);

  mgr_idx_t dst_idx;
  logic     dst_ok;

  // Upper ID bits name the manager
  assign dst_idx = in_b.id[sub_id_w-1 -: mgr_idx_w];
  assign dst_ok = int'(dst_idx) < num_mgr;

  always_comb begin
    for (int i = 0; i < num_mgr; i++) begin
      out_valid[i] = in_valid && (dst_idx == mgr_idx_t'(i));
      out_b[i].id = in_b.id[mgr_id_w-1:0];
      out_b[i].resp = in_b.resp;
    end
  end

  // Responses with an unknown index are drained
  assign in_ready = dst_ok ? out_ready[dst_idx] : 1'b1;

endmodule

`default_nettype wire

// ==== hw/axi_arbiter_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter_wr
  import axi_wr_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                [num_mgr-1:0] mgr_aw_valid,
  input  mgr_aw_t [num_mgr-1:0]             mgr_aw,
  output logic                [num_mgr-1:0] mgr_aw_ready,

  input  logic                [num_mgr-1:0] mgr_w_valid,
  input  w_beat_t [num_mgr-1:0]             mgr_w,
  output logic                [num_mgr-1:0] mgr_w_ready,

  output logic                [num_mgr-1:0] mgr_b_valid,
  output mgr_b_t [num_mgr-1:0]              mgr_b,
  input  logic                [num_mgr-1:0] mgr_b_ready,

  output logic                              sub_aw_valid,
  output sub_aw_t                           sub_aw,
  input  logic                              sub_aw_ready,

  output logic                              sub_w_valid,
  output w_beat_t                           sub_w,
  input  logic                              sub_w_ready,

  input  logic                              sub_b_valid,
  input  sub_b_t                            sub_b,
  output logic                              sub_b_ready
);

  mgr_idx_t grant_idx;
  logic     aw_grant;
  logic     w_open;
  logic     w_done;

  logic     aw_slice_valid;
  logic     aw_slice_ready;
  sub_aw_t  aw_slice_data;

  logic                 [num_mgr-1:0] b_route_valid;
  mgr_b_t [num_mgr-1:0]               b_route_b;
  logic                 [num_mgr-1:0] b_route_ready;

  logic          b_slice_in_valid;
  logic          b_slice_in_ready;
  mgr_b_bundle_t b_slice_in;
  logic          b_slice_out_valid;
  logic          b_slice_out_ready;
  mgr_b_bundle_t b_slice_out;

  axi_wr_grant_ctrl i_grant_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .aw_req       (mgr_aw_valid),
    .aw_slot_ready(aw_slice_ready),
    .w_done       (w_done),
    .grant_idx    (grant_idx),
    .aw_grant     (aw_grant),
    .w_open       (w_open)
  );

  axi_aw_mux i_aw_mux (
    .mgr_aw_valid(mgr_aw_valid),
    .mgr_aw      (mgr_aw),
    .mgr_aw_ready(mgr_aw_ready),
    .grant_idx   (grant_idx),
    .aw_grant    (aw_grant),
    .aw_out_valid(aw_slice_valid),
    .aw_out      (aw_slice_data)
  );

  axi_reg_slice #(
    .payload_t(sub_aw_t)
  ) i_aw_slice (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (aw_slice_valid),
    .in_ready (aw_slice_ready),
    .in_data  (aw_slice_data),
    .out_valid(sub_aw_valid),
    .out_ready(sub_aw_ready),
    .out_data (sub_aw)
  );

  axi_w_mux i_w_mux (
    .mgr_w_valid(mgr_w_valid),
    .mgr_w      (mgr_w),
    .mgr_w_ready(mgr_w_ready),
    .grant_idx  (grant_idx),
    .w_open     (w_open),
    .sub_w_valid(sub_w_valid),
    .sub_w      (sub_w),
    .sub_w_ready(sub_w_ready),
    .w_done     (w_done)
  );

  axi_b_route i_b_route (
    .in_valid (sub_b_valid),
    .in_b     (sub_b),
    .in_ready (sub_b_ready),
    .out_valid(b_route_valid),
    .out_b    (b_route_b),
    .out_ready(b_route_ready)
  );

  // Routed response is registered as one bundle
  assign b_slice_in_valid = |b_route_valid;
  assign b_slice_in.sel = b_route_valid;
  assign b_slice_in.b = b_route_b;
  assign b_route_ready = {num_mgr{b_slice_in_ready}};

  axi_reg_slice #(
    .payload_t(mgr_b_bundle_t)
  ) i_b_slice (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (b_slice_in_valid),
    .in_ready (b_slice_in_ready),
    .in_data  (b_slice_in),
    .out_valid(b_slice_out_valid),
    .out_ready(b_slice_out_ready),
    .out_data (b_slice_out)
  );

  assign mgr_b_valid = b_slice_out.sel & {num_mgr{b_slice_out_valid}};
  assign mgr_b = b_slice_out.b;
  assign b_slice_out_ready = |(b_slice_out.sel & mgr_b_ready);

endmodule

`default_nettype wire

// ==== tests/axi_arbiter_wr_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter_wr_chk
  import axi_wr_pkg::*;
(
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               sub_aw_valid,
  input wire logic               sub_aw_ready,
  input wire sub_aw_t            sub_aw,
  input wire logic               sub_w_valid,
  input wire logic               sub_w_ready,
  input wire w_beat_t            sub_w,
  input wire logic [num_mgr-1:0] mgr_aw_ready,
  input wire logic [num_mgr-1:0] mgr_b_valid
);

  // Stalled beats hold their payload
  aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sub_aw_valid && !sub_aw_ready |=> sub_aw_valid && $stable(sub_aw))
    else $error("sub AW changed under stall");

  w_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sub_w_valid && !sub_w_ready |=> sub_w_valid && $stable(sub_w))
    else $error("sub W changed under stall");

  aw_grant_one: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(mgr_aw_ready))
    else $error("more than one manager AW ready");

  b_route_one: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(mgr_b_valid))
    else $error("B valid to more than one manager");

endmodule

bind axi_arbiter_wr axi_arbiter_wr_chk i_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .sub_aw_valid(sub_aw_valid),
  .sub_aw_ready(sub_aw_ready),
  .sub_aw      (sub_aw),
  .sub_w_valid (sub_w_valid),
  .sub_w_ready (sub_w_ready),
  .sub_w       (sub_w),
  .mgr_aw_ready(mgr_aw_ready),
  .mgr_b_valid (mgr_b_valid)
);

`default_nettype wire

// ==== tests/axi_arbiter_wr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter_wr_tb
  import axi_wr_pkg::*;
;

  localparam int num_tests = 5;

  logic clk;
  logic rst_n;

  logic    [num_mgr-1:0] mgr_aw_valid;
  mgr_aw_t [num_mgr-1:0] mgr_aw;
  logic    [num_mgr-1:0] mgr_aw_ready;
  logic    [num_mgr-1:0] mgr_w_valid;
  w_beat_t [num_mgr-1:0] mgr_w;
  logic    [num_mgr-1:0] mgr_w_ready;
  logic    [num_mgr-1:0] mgr_b_valid;
  mgr_b_t  [num_mgr-1:0] mgr_b;
  logic    [num_mgr-1:0] mgr_b_ready;

  logic    sub_aw_valid;
  sub_aw_t sub_aw;
  logic    sub_aw_ready;
  logic    sub_w_valid;
  w_beat_t sub_w;
  logic    sub_w_ready;
  logic    sub_b_valid;
  sub_b_t  sub_b;
  logic    sub_b_ready;

  integer  seed = 20613;
  int      errors = 0;
  bit      stall_en = 1'b0;
  int      aw_cnt = 0;
  int      wlast_cnt = 0;
  sub_aw_t aw_q[$];
  w_beat_t w_q[$];

  axi_arbiter_wr i_axi_arbiter_wr (.*);

  always #4 clk = ~clk;

  initial begin
    #(num_tests * 2000);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  // Subordinate ready, random when stalls are on
  always @(posedge clk) begin
    #1;
    sub_aw_ready = stall_en ? 1'($random(seed)) : 1'b1;
    sub_w_ready = stall_en ? 1'($random(seed)) : 1'b1;
  end

  // Subordinate model records beats where the bus is stable
  always @(negedge clk) begin
    if (rst_n && sub_w_valid && sub_w_ready) begin
      w_q.push_back(sub_w);
      if (sub_w.last) begin
        wlast_cnt++;
      end
    end
    if (rst_n && sub_aw_valid && sub_aw_ready) begin
      assert (wlast_cnt >= aw_cnt) else begin
        $display("AW reached the subordinate before the previous burst's last W beat");
        errors++;
      end
      aw_cnt++;
      aw_q.push_back(sub_aw);
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic send_aw(input int m, input mgr_aw_t a);
    mgr_aw[m] = a;
    mgr_aw_valid[m] = 1'b1;
    do @(negedge clk); while (!mgr_aw_ready[m]);
    @(posedge clk);
    #1;
    mgr_aw_valid[m] = 1'b0;
  endtask

  task automatic send_w(input int m, input logic [15:0] base, input int n);
    for (int b = 0; b < n; b++) begin
      mgr_w[m] = '{data: base + 16'(b), strb: 2'b11, last: (b == n - 1)};
      mgr_w_valid[m] = 1'b1;
      do @(negedge clk); while (!mgr_w_ready[m]);
      @(posedge clk);
      #1;
    end
    mgr_w_valid[m] = 1'b0;
  endtask

  task automatic send_sub_b(input logic [sub_id_w-1:0] id, input logic [1:0] resp);
    sub_b = '{id: id, resp: resp};
    sub_b_valid = 1'b1;
    do @(negedge clk); while (!sub_b_ready);
    @(posedge clk);
    #1;
    sub_b_valid = 1'b0;
  endtask

  task automatic recv_b(input int m, input bit stall, output mgr_b_t got);
    bit done;
    done = 1'b0;
    while (!done) begin
      mgr_b_ready[m] = stall ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      if (mgr_b_valid[m] && mgr_b_ready[m]) begin
        got = mgr_b[m];
        check_true($onehot(mgr_b_valid), "a second manager saw b_valid with the response");
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    mgr_b_ready[m] = 1'b0;
  endtask

  task automatic wait_sub_beats(input int n_aw, input int n_w);
    while (aw_q.size() < n_aw || w_q.size() < n_w) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_reset_state();
    check_val("sub_aw_valid", sub_aw_valid, 0);
    check_val("sub_w_valid", sub_w_valid, 0);
    check_val("mgr_b_valid", mgr_b_valid, 0);
  endtask

  task automatic test_single_burst();
    mgr_aw_t a;
    aw_q.delete();
    w_q.delete();
    a = '{id: 4'h5, addr: 20'h12340, len: 8'd1, size: 3'd1, burst: 2'b01};
    fork
      send_aw(0, a);
      send_w(0, 16'hA001, 2);
    join
    wait_sub_beats(1, 2);
    check_val("sub_aw.id", aw_q[0].id, {2'b00, 4'h5});
    check_val("sub_aw.addr", aw_q[0].addr, 20'h12340);
    check_val("sub_aw.len", aw_q[0].len, 1);
    check_val("sub_aw.size", aw_q[0].size, 1);
    check_val("sub_aw.burst", aw_q[0].burst, 1);
    for (int b = 0; b < 2; b++) begin
      check_val("sub_w.data", w_q[b].data, 16'hA001 + b);
      check_val("sub_w.strb", w_q[b].strb, 2'b11);
      check_val("sub_w.last", w_q[b].last, b == 1);
    end
  endtask

  task automatic test_three_managers();
    aw_q.delete();
    w_q.delete();
    for (int m = 0; m < num_mgr; m++) begin
      fork
        automatic int mm = m;
        send_aw(mm, '{id: 4'(mm + 8), addr: 20'(mm * 256), len: 8'd1, size: 3'd1,
                      burst: 2'b01});
        send_w(mm, 16'(mm << 12) | 16'h0100, 2);
      join_none
    end
    wait fork;
    wait_sub_beats(3, 6);
    for (int i = 0; i < num_mgr; i++) begin
      check_val("sub_aw.id", aw_q[i].id, {2'(i), 4'(i + 8)});
      check_val("sub_w.data", w_q[2 * i].data, 16'(i << 12) | 16'h0100);
      check_val("sub_w.data", w_q[2 * i + 1].data, 16'(i << 12) | 16'h0101);
    end
  endtask

  // Returns the three open bursts out of order
  task automatic test_ooo_responses();
    int order[3] = '{2, 0, 1};
    mgr_b_t got;
    foreach (order[k]) begin
      fork
        send_sub_b({2'(order[k]), 4'(order[k] + 8)}, 2'(k + 1));
        recv_b(order[k], 1'b0, got);
      join
      check_val("mgr_b.id", got.id, order[k] + 8);
      check_val("mgr_b.resp", got.resp, k + 1);
    end
  endtask

  task automatic test_random_stalls();
    mgr_aw_t a;
    mgr_b_t got;
    int m;
    logic [15:0] base;
    logic [1:0] resp;
    stall_en = 1'b1;
    for (int n = 0; n < 12; n++) begin
      aw_q.delete();
      w_q.delete();
      m = $unsigned($random(seed)) % num_mgr;
      base = 16'($random(seed));
      resp = 2'($random(seed));
      a = '{id: 4'($random(seed)), addr: 20'($random(seed)), len: 8'($unsigned($random(seed)) % 4),
            size: 3'd1, burst: 2'b01};
      fork
        send_aw(m, a);
        send_w(m, base, a.len + 1);
      join
      wait_sub_beats(1, a.len + 1);
      check_val("sub_aw.id", aw_q[0].id, {2'(m), a.id});
      check_val("sub_aw.addr", aw_q[0].addr, a.addr);
      check_val("sub_aw.len", aw_q[0].len, a.len);
      for (int b = 0; b <= a.len; b++) begin
        check_val("sub_w.data", w_q[b].data, base + 16'(b));
        check_val("sub_w.last", w_q[b].last, b == a.len);
      end
      fork
        send_sub_b({2'(m), a.id}, resp);
        recv_b(m, 1'b1, got);
      join
      check_val("mgr_b.id", got.id, a.id);
      check_val("mgr_b.resp", got.resp, resp);
      repeat (3) @(posedge clk);
      #1;
      check_true(aw_q.size() == 1 && w_q.size() == a.len + 1, "extra beats reached the subordinate");
      check_val("mgr_b_valid", mgr_b_valid, 0);
    end
    stall_en = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    mgr_aw_valid = '0;
    mgr_aw = '0;
    mgr_w_valid = '0;
    mgr_w = '0;
    mgr_b_ready = '0;
    sub_aw_ready = 1'b1;
    sub_w_ready = 1'b1;
    sub_b_valid = 1'b0;
    sub_b = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    // Round-robin pointer is still at manager 0 here
    test_three_managers();
    test_ooo_responses();
    test_single_burst();
    test_random_stalls();
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
common/axi_wr_pkg.sv
hw/axi_wr_grant_ctrl.sv
hw/axi_reg_slice.sv
hw/axi_aw_mux.sv
hw/axi_w_mux.sv
hw/axi_b_route.sv
hw/axi_arbiter_wr.sv
tests/axi_arbiter_wr_chk.sv
tests/axi_arbiter_wr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
  --top-module axi_arbiter_wr_tb -o sim_axi_arbiter_wr

./obj_dir/sim_axi_arbiter_wr 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  exit 1
fi
exit 0
